// File: Makefile
# Verilator build and run of the peripheral wrapper testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps --top-module tb_top \
		-f build.f -Mdir obj_dir -o sim_tb

run: compile
	./obj_dir/sim_tb > sim.log 2>&1
	cat sim.log
	@! grep -q "Done: errors found" sim.log

clean:
	rm -rf obj_dir sim.log

// File: build.f
+incdir+hdl
hdl/periph_pkg.sv
hdl/periph_decode.sv
hdl/read_buffer.sv
hdl/gpio_ctrl.sv
hdl/word_reg_periph.sv
hdl/byte_reg_periph.sv
hdl/periph_top.sv
tb/periph_checker.sv
tb/tb_top.sv

// File: hdl/byte_reg_periph.sv
// Simple-slot peripheral with four byte registers
`timescale 1ns/1ps

module byte_reg_periph (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [3:0]        i_offset,
    input  logic              i_write,
    input  periph_pkg::byte_t i_wdata,
    output periph_pkg::byte_t o_rdata,
    output periph_pkg::byte_t o_pins
);

    periph_pkg::byte_t regs_q [4];
    logic              in_range;
    logic [1:0]        idx;

    assign in_range = (i_offset < 4'd4);
    assign idx      = i_offset[1:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                regs_q[i] <= '0;
            end
        end else if (i_write && in_range) begin
            regs_q[idx] <= i_wdata;
        end
    end

    // Offsets 4 to 15 read as zero
    assign o_rdata = in_range ? regs_q[idx] : '0;
    assign o_pins  = regs_q[0];

endmodule

// File: hdl/gpio_ctrl.sv
// GPIO output register, pin function selects, readback and output-pin mux
`timescale 1ns/1ps
`include "periph_settings.svh"

module gpio_ctrl (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              i_write,
    input  logic [5:0]        i_offset,
    input  periph_pkg::byte_t i_wdata,
    input  periph_pkg::byte_t i_ui_in,
    input  periph_pkg::byte_t i_wreg_pins,
    input  periph_pkg::byte_t i_breg_pins,
    output periph_pkg::word_t o_rdata,
    output periph_pkg::byte_t o_uo_out
);

    localparam int SEL_W  = $bits(periph_pkg::pin_sel_t);
    localparam int SLOT_W = SEL_W - 1;

    periph_pkg::byte_t    gpio_out_q;
    periph_pkg::pin_sel_t func_sel_q [`PERI_PINS];

    logic       is_out;
    logic       is_in;
    logic       is_sel;
    logic [5:0] sel_ofs;
    logic [2:0] sel_idx;

    assign is_out  = (i_offset == 6'(`GPIO_OUT_OFS));
    assign is_in   = (i_offset == 6'(`GPIO_IN_OFS));
    assign sel_ofs = i_offset - 6'(`GPIO_SEL_BASE);
    // Word-aligned offsets from the select base up to the top of the slot
    assign is_sel  = (i_offset >= 6'(`GPIO_SEL_BASE)) && (i_offset[1:0] == 2'b00);
    assign sel_idx = sel_ofs[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out_q <= '0;
        end else if (i_write && is_out) begin
            gpio_out_q <= i_wdata;
        end
    end

    // All pins come out of reset on the GPIO register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `PERI_PINS; i++) begin
                func_sel_q[i] <= SEL_W'(`GPIO_SLOT);
            end
        end else if (i_write && is_sel) begin
            func_sel_q[sel_idx] <= i_wdata[SEL_W-1:0];
        end
    end

    always_comb begin
        o_rdata = '0;
        if (is_out) begin
            o_rdata = {24'h0, gpio_out_q};
        end else if (is_in) begin
            o_rdata = {24'h0, i_ui_in};
        end else if (is_sel) begin
            o_rdata = {{(32 - SEL_W){1'b0}}, func_sel_q[sel_idx]};
        end
    end

    // Each pin picks its bit from the slot named by its select
    always_comb begin
        logic [SLOT_W-1:0] slot;
        for (int i = 0; i < `PERI_PINS; i++) begin
            slot        = func_sel_q[i][SLOT_W-1:0];
            o_uo_out[i] = 1'b0;
            if (func_sel_q[i][SEL_W-1]) begin
                if (slot == SLOT_W'(`BREG_SLOT)) begin
                    o_uo_out[i] = i_breg_pins[i];
                end
            end else if (slot == SLOT_W'(`GPIO_SLOT)) begin
                o_uo_out[i] = gpio_out_q[i];
            end else if (slot == SLOT_W'(`WREG_SLOT)) begin
                o_uo_out[i] = i_wreg_pins[i];
            end
        end
    end

endmodule

// File: hdl/periph_decode.sv
// Slot decode, request gating and read data/ready multiplexer
`timescale 1ns/1ps
`include "periph_settings.svh"

module periph_decode (
    input  periph_pkg::addr_t i_addr,
    input  periph_pkg::xfer_e i_write_n,
    input  periph_pkg::xfer_e i_read_n,
    input  periph_pkg::word_t i_gpio_rdata,
    input  periph_pkg::word_t i_wreg_rdata,
    input  logic              i_wreg_ready,
    input  periph_pkg::byte_t i_breg_rdata,
    output logic              o_gpio_write,
    output periph_pkg::xfer_e o_wreg_write_n,
    output periph_pkg::xfer_e o_wreg_read_n,
    output logic              o_breg_write,
    output periph_pkg::word_t o_rdata,
    output logic              o_rready
);

    localparam int SLOT_W = $clog2(`PERI_SLOTS);

    logic              is_simple;
    logic [SLOT_W-1:0] slot;
    logic              write_req;

    // User slots are 64 bytes wide, simple slots 16 bytes
    assign is_simple = i_addr[`PERI_ADDR_W-1];
    assign slot      = is_simple ? i_addr[7:4] : i_addr[9:6];
    assign write_req = (i_write_n != periph_pkg::XFER_NONE);

    always_comb begin
        o_gpio_write   = 1'b0;
        o_wreg_write_n = periph_pkg::XFER_NONE;
        o_wreg_read_n  = periph_pkg::XFER_NONE;
        o_breg_write   = 1'b0;
        // Empty slots answer at once with zero data
        o_rdata        = '0;
        o_rready       = 1'b1;

        if (is_simple) begin
            if (slot == SLOT_W'(`BREG_SLOT)) begin
                o_breg_write = write_req;
                o_rdata      = {24'h0, i_breg_rdata};
            end
        end else begin
            if (slot == SLOT_W'(`GPIO_SLOT)) begin
                o_gpio_write = write_req;
                o_rdata      = i_gpio_rdata;
            end else if (slot == SLOT_W'(`WREG_SLOT)) begin
                // Full interface sees the width code and has its own ready
                o_wreg_write_n = i_write_n;
                o_wreg_read_n  = i_read_n;
                o_rdata        = i_wreg_rdata;
                o_rready       = i_wreg_ready;
            end
        end
    end

endmodule

// File: hdl/periph_pkg.sv
// Bus data, address and pin-select types plus the transfer-width code
`include "periph_settings.svh"

package periph_pkg;

    // Full bus data word
    typedef logic [31:0] word_t;

    // Byte lane, also used for the pin vectors
    typedef logic [`PERI_PINS-1:0] byte_t;

    // Peripheral address
    typedef logic [`PERI_ADDR_W-1:0] addr_t;

    // Pin function select: top bit picks a simple slot, low bits the slot number
    typedef logic [$clog2(`PERI_SLOTS):0] pin_sel_t;

    // Request code on the read and write lines, all ones means idle
    typedef enum logic [1:0] {
        XFER_8    = 2'b00,
        XFER_16   = 2'b01,
        XFER_32   = 2'b10,
        XFER_NONE = 2'b11
    } xfer_e;

endpackage

// File: hdl/periph_settings.svh
// Address map, slot numbers and register offsets of the peripheral wrapper
`ifndef PERIPH_SETTINGS_SVH
`define PERIPH_SETTINGS_SVH

// Peripheral address bus width, bit 10 selects the simple slots
`define PERI_ADDR_W 11

// Slots per kind (user and simple)
`define PERI_SLOTS 16

// Output and input pin count
`define PERI_PINS 8

// Populated slots
`define GPIO_SLOT 1
`define WREG_SLOT 4
`define BREG_SLOT 0

// GPIO register offsets inside its 64-byte slot
`define GPIO_OUT_OFS 0
`define GPIO_IN_OFS 4

// Function selects for pins 0 to 7, one word apart from here
`define GPIO_SEL_BASE 32

`endif

// File: hdl/periph_top.sv
// Peripheral wrapper top: decode, read buffer, GPIO and the two peripherals
`timescale 1ns/1ps

module periph_top (
    input  logic              clk,
    input  logic              rst_n,
    input  periph_pkg::addr_t i_addr,
    input  periph_pkg::word_t i_data,
    input  periph_pkg::xfer_e i_write_n,
    input  periph_pkg::xfer_e i_read_n,
    input  logic              i_read_complete,
    input  periph_pkg::byte_t i_ui_in,
    output periph_pkg::word_t o_data,
    output logic              o_data_ready,
    output periph_pkg::byte_t o_uo_out
);

    periph_pkg::xfer_e read_n_masked;
    periph_pkg::word_t peri_rdata;
    logic              peri_rready;

    logic              gpio_write;
    periph_pkg::word_t gpio_rdata;

    periph_pkg::xfer_e wreg_write_n;
    periph_pkg::xfer_e wreg_read_n;
    periph_pkg::word_t wreg_rdata;
    logic              wreg_ready;
    periph_pkg::byte_t wreg_pins;

    logic              breg_write;
    periph_pkg::byte_t breg_rdata;
    periph_pkg::byte_t breg_pins;

    periph_decode u_decode (
        .i_addr         (i_addr),
        .i_write_n      (i_write_n),
        .i_read_n       (read_n_masked),
        .i_gpio_rdata   (gpio_rdata),
        .i_wreg_rdata   (wreg_rdata),
        .i_wreg_ready   (wreg_ready),
        .i_breg_rdata   (breg_rdata),
        .o_gpio_write   (gpio_write),
        .o_wreg_write_n (wreg_write_n),
        .o_wreg_read_n  (wreg_read_n),
        .o_breg_write   (breg_write),
        .o_rdata        (peri_rdata),
        .o_rready       (peri_rready)
    );

    read_buffer u_read_buffer (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_read_n        (i_read_n),
        .i_write_n       (i_write_n),
        .i_rdata         (peri_rdata),
        .i_rready        (peri_rready),
        .i_read_complete (i_read_complete),
        .o_read_n_masked (read_n_masked),
        .o_data          (o_data),
        .o_data_ready    (o_data_ready)
    );

    gpio_ctrl u_gpio (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_write     (gpio_write),
        .i_offset    (i_addr[5:0]),
        .i_wdata     (i_data[7:0]),
        .i_ui_in     (i_ui_in),
        .i_wreg_pins (wreg_pins),
        .i_breg_pins (breg_pins),
        .o_rdata     (gpio_rdata),
        .o_uo_out    (o_uo_out)
    );

    word_reg_periph u_wreg (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_offset  (i_addr[5:0]),
        .i_wdata   (i_data),
        .i_write_n (wreg_write_n),
        .i_read_n  (wreg_read_n),
        .o_rdata   (wreg_rdata),
        .o_ready   (wreg_ready),
        .o_pins    (wreg_pins)
    );

    byte_reg_periph u_breg (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_offset (i_addr[3:0]),
        .i_write  (breg_write),
        .i_wdata  (i_data[7:0]),
        .o_rdata  (breg_rdata),
        .o_pins   (breg_pins)
    );

endmodule

// File: hdl/read_buffer.sv
// Registered read data, hold flag and ready, with the peripheral read mask
`timescale 1ns/1ps

module read_buffer (
    input  logic              clk,
    input  logic              rst_n,
    input  periph_pkg::xfer_e i_read_n,
    input  periph_pkg::xfer_e i_write_n,
    input  periph_pkg::word_t i_rdata,
    input  logic              i_rready,
    input  logic              i_read_complete,
    output periph_pkg::xfer_e o_read_n_masked,
    output periph_pkg::word_t o_data,
    output logic              o_data_ready
);

    logic              read_req;
    logic              capture;
    logic              hold_q;
    logic              ready_q;
    periph_pkg::word_t data_q;

    assign read_req = (i_read_n != periph_pkg::XFER_NONE);
    assign capture  = !hold_q && i_rready && read_req;

    // No second peripheral read while the result sits in the buffer
    assign o_read_n_masked = ready_q ? periph_pkg::XFER_NONE : i_read_n;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_q  <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            if (i_read_complete) begin
                hold_q <= 1'b0;
            end
            if (capture) begin
                hold_q <= 1'b1;
            end
            // Set one cycle after a read meets peripheral ready
            ready_q <= read_req && i_rready;
        end
    end

    // Held until the core signals it has taken the word
    always_ff @(posedge clk) begin
        if (capture) begin
            data_q <= i_rdata;
        end
    end

    assign o_data       = data_q;
    assign o_data_ready = ready_q || (i_write_n != periph_pkg::XFER_NONE);

endmodule

// File: hdl/word_reg_periph.sv
// User-slot peripheral with four 32-bit registers and width-coded writes
`timescale 1ns/1ps

module word_reg_periph (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [5:0]        i_offset,
    input  periph_pkg::word_t i_wdata,
    input  periph_pkg::xfer_e i_write_n,
    input  periph_pkg::xfer_e i_read_n,
    output periph_pkg::word_t o_rdata,
    output logic              o_ready,
    output periph_pkg::byte_t o_pins
);

    periph_pkg::word_t regs_q [4];
    logic              ready_q;
    logic              in_range;
    logic [1:0]        idx;

    // Registers live in the first 16 bytes of the slot
    assign in_range = (i_offset < 6'd16);
    assign idx      = i_offset[3:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                regs_q[i] <= '0;
            end
        end else if (in_range) begin
            // Narrow writes leave the upper bits alone
            case (i_write_n)
                periph_pkg::XFER_8:  regs_q[idx][7:0]  <= i_wdata[7:0];
                periph_pkg::XFER_16: regs_q[idx][15:0] <= i_wdata[15:0];
                periph_pkg::XFER_32: regs_q[idx]       <= i_wdata;
                default: ;
            endcase
        end
    end

    // One cycle of read latency
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= (i_read_n != periph_pkg::XFER_NONE);
        end
    end

    assign o_rdata = in_range ? regs_q[idx] : '0;
    assign o_ready = ready_q;
    assign o_pins  = regs_q[0][7:0];

endmodule

// File: tb/periph_checker.sv
// Register model, expected read and pin values, and the read, pin and handshake checks
`timescale 1ns/1ps
`include "periph_settings.svh"

module periph_checker (
    input  logic              clk,
    input  logic              rst_n,
    input  periph_pkg::addr_t i_addr,
    input  periph_pkg::word_t i_data,
    input  periph_pkg::xfer_e i_write_n,
    input  periph_pkg::xfer_e i_read_n,
    input  logic              i_read_complete,
    input  periph_pkg::byte_t i_ui_in,
    input  periph_pkg::word_t i_rdata,
    input  logic              i_data_ready,
    input  periph_pkg::byte_t i_uo_out,
    output int                o_mismatches,
    output int                o_failures,
    output int                o_reads,
    output int                o_writes
);

    periph_pkg::byte_t    gpio_out;
    periph_pkg::pin_sel_t pin_sel [`PERI_PINS];
    periph_pkg::word_t    wregs [4];
    periph_pkg::byte_t    bregs [4];
    periph_pkg::word_t    held_word;
    logic                 request_seen;

    // Expected read word at an address, taken from the model
    function automatic periph_pkg::word_t expect_read(input periph_pkg::addr_t a,
                                                      input periph_pkg::byte_t ui);
        logic [5:0] ofs;
        logic [2:0] pin;
        ofs = a[5:0];
        pin = 3'((int'(ofs) - `GPIO_SEL_BASE) / 4);
        if (a[10]) begin
            // Simple slots: 16 bytes each, slot number in bits 7:4
            if (a[7:4] == 4'(`BREG_SLOT) && a[3:0] < 4'd4) begin
                return {24'h0, bregs[a[1:0]]};
            end
        end else if (a[9:6] == 4'(`GPIO_SLOT)) begin
            if (ofs == 6'(`GPIO_OUT_OFS)) begin
                return {24'h0, gpio_out};
            end else if (ofs == 6'(`GPIO_IN_OFS)) begin
                return {24'h0, ui};
            end else if (ofs >= 6'(`GPIO_SEL_BASE) && ofs[1:0] == 2'b00) begin
                return {27'h0, pin_sel[pin]};
            end
        end else if (a[9:6] == 4'(`WREG_SLOT) && ofs < 6'd16) begin
            return wregs[ofs[3:2]];
        end
        return '0;
    endfunction

    // Expected output pins, empty source slots give 0
    function automatic periph_pkg::byte_t expect_pins();
        periph_pkg::byte_t pins;
        pins = '0;
        for (int i = 0; i < `PERI_PINS; i++) begin
            if (pin_sel[i] == {1'b1, 4'(`BREG_SLOT)}) begin
                pins[i] = bregs[0][i];
            end else if (pin_sel[i] == {1'b0, 4'(`GPIO_SLOT)}) begin
                pins[i] = gpio_out[i];
            end else if (pin_sel[i] == {1'b0, 4'(`WREG_SLOT)}) begin
                pins[i] = wregs[0][i];
            end
        end
        return pins;
    endfunction

    task automatic apply_write(input periph_pkg::addr_t a, input periph_pkg::word_t d,
                               input periph_pkg::xfer_e code);
        logic [5:0] ofs;
        logic [1:0] w;
        ofs = a[5:0];
        w   = ofs[3:2];
        if (a[10]) begin
            if (a[7:4] == 4'(`BREG_SLOT) && a[3:0] < 4'd4) begin
                bregs[a[1:0]] = d[7:0];
            end
        end else if (a[9:6] == 4'(`GPIO_SLOT)) begin
            // GPIO takes the low byte whatever the width
            if (ofs == 6'(`GPIO_OUT_OFS)) begin
                gpio_out = d[7:0];
            end else if (ofs >= 6'(`GPIO_SEL_BASE) && ofs[1:0] == 2'b00) begin
                pin_sel[3'((int'(ofs) - `GPIO_SEL_BASE) / 4)] = d[4:0];
            end
        end else if (a[9:6] == 4'(`WREG_SLOT) && ofs < 6'd16) begin
            case (code)
                periph_pkg::XFER_8:  wregs[w] = {wregs[w][31:8], d[7:0]};
                periph_pkg::XFER_16: wregs[w] = {wregs[w][31:16], d[15:0]};
                default:             wregs[w] = d;
            endcase
        end
    endtask

    // Sampled mid-cycle, pins compared before this cycle's write lands
    always @(negedge clk) begin
        if (!rst_n) begin
            gpio_out = '0;
            for (int i = 0; i < `PERI_PINS; i++) begin
                pin_sel[i] = periph_pkg::pin_sel_t'(`GPIO_SLOT);
            end
            for (int i = 0; i < 4; i++) begin
                wregs[i] = '0;
                bregs[i] = '0;
            end
            request_seen = 1'b0;
            o_mismatches = 0;
            o_failures   = 0;
            o_reads      = 0;
            o_writes     = 0;
        end else begin
            if (i_uo_out !== expect_pins()) begin
                $display("Mismatch at %0t: o_uo_out expected %h got %h",
                         $time, expect_pins(), i_uo_out);
                o_mismatches++;
            end
            if (i_write_n != periph_pkg::XFER_NONE || i_read_n != periph_pkg::XFER_NONE) begin
                request_seen = 1'b1;
            end else if (!request_seen && i_data_ready) begin
                $display("Error at %0t: o_data_ready high after reset with no request", $time);
                o_failures++;
            end
            if (i_write_n != periph_pkg::XFER_NONE) begin
                if (!i_data_ready) begin
                    $display("Error at %0t: write to %h was not acknowledged at once",
                             $time, i_addr);
                    o_failures++;
                end else begin
                    apply_write(i_addr, i_data, i_write_n);
                    o_writes++;
                end
            end
            if (i_read_n != periph_pkg::XFER_NONE && i_data_ready) begin
                held_word = expect_read(i_addr, i_ui_in);
                o_reads++;
                if (i_rdata !== held_word) begin
                    $display("Mismatch at %0t: read of %h expected %h got %h",
                             $time, i_addr, held_word, i_rdata);
                    o_mismatches++;
                end
            end
            // Data must still be there when the core signals it has taken it
            if (i_read_complete && i_rdata !== held_word) begin
                $display("Mismatch at %0t: o_data changed to %h before read complete",
                         $time, i_rdata);
                o_mismatches++;
            end
        end
    end

endmodule

// File: tb/tb_top.sv
// Testbench top: clock, reset, LFSR-driven core transfers and the run timeout
`timescale 1ns/1ps
`include "periph_settings.svh"

module tb_top;

    // 400 random transfers at up to 6 cycles each, plus reset and select reads
    localparam int N_RANDOM    = 400;
    localparam int CYCLE_LIMIT = 4000;

    logic              clk;
    logic              rst_n;
    periph_pkg::addr_t addr;
    periph_pkg::word_t data_in;
    periph_pkg::xfer_e write_n;
    periph_pkg::xfer_e read_n;
    logic              read_complete;
    periph_pkg::byte_t ui_in;
    periph_pkg::word_t data_out;
    logic              data_ready;
    periph_pkg::byte_t uo_out;
    logic [31:0]       lfsr_state;
    int                cycle_count = 0;
    int                mismatches;
    int                failures;
    int                reads;
    int                writes;

    periph_top dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_addr          (addr),
        .i_data          (data_in),
        .i_write_n       (write_n),
        .i_read_n        (read_n),
        .i_read_complete (read_complete),
        .i_ui_in         (ui_in),
        .o_data          (data_out),
        .o_data_ready    (data_ready),
        .o_uo_out        (uo_out)
    );

    periph_checker u_checker (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_addr          (addr),
        .i_data          (data_in),
        .i_write_n       (write_n),
        .i_read_n        (read_n),
        .i_read_complete (read_complete),
        .i_ui_in         (ui_in),
        .i_rdata         (data_out),
        .i_data_ready    (data_ready),
        .i_uo_out        (uo_out),
        .o_mismatches    (mismatches),
        .o_failures      (failures),
        .o_reads         (reads),
        .o_writes        (writes)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Fibonacci LFSR with taps 32 22 2 1, one step per bit drawn
    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            bits = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    // Mostly populated slots, plus empty user slot 7 and empty simple slot 9
    task automatic pick_address(output periph_pkg::addr_t a, output logic is_sel);
        logic [31:0] kind;
        logic [31:0] r;
        kind   = draw_bits(3);
        r      = draw_bits(5);
        is_sel = 1'b0;
        case (kind[2:0])
            3'd0, 3'd1: begin
                is_sel = r[4];
                if (r[4]) begin
                    a = {1'b0, 4'(`GPIO_SLOT), 6'(`GPIO_SEL_BASE) + {1'b0, r[2:0], 2'b00}};
                end else begin
                    a = {1'b0, 4'(`GPIO_SLOT), r[3] ? 6'(`GPIO_IN_OFS) : 6'(`GPIO_OUT_OFS)};
                end
            end
            3'd2, 3'd3: begin
                a = {1'b0, 4'(`WREG_SLOT), r[4] ? {r[3:0], 2'b00} : {2'b00, r[1:0], 2'b00}};
            end
            3'd4, 3'd5: begin
                a = {1'b1, 2'b00, 4'(`BREG_SLOT), r[4] ? r[3:0] : {2'b00, r[1:0]}};
            end
            3'd6:    a = {1'b0, 4'd7, r[4:0], 1'b0};
            default: a = {1'b1, 2'b00, 4'd9, r[3:0]};
        endcase
    endtask

    task automatic wait_ready();
        @(negedge clk);
        while (!data_ready) begin
            @(negedge clk);
        end
    endtask

    // Request held until o_data_ready, reads then get a one-cycle complete pulse
    task automatic transfer(input periph_pkg::addr_t a, input periph_pkg::word_t d,
                            input periph_pkg::xfer_e code, input logic is_write,
                            input periph_pkg::byte_t ui);
        @(posedge clk);
        addr    <= a;
        data_in <= d;
        ui_in   <= ui;
        if (is_write) begin
            write_n <= code;
        end else begin
            read_n <= code;
        end
        wait_ready();
        @(posedge clk);
        write_n <= periph_pkg::XFER_NONE;
        read_n  <= periph_pkg::XFER_NONE;
        if (!is_write) begin
            read_complete <= 1'b1;
            @(posedge clk);
            read_complete <= 1'b0;
        end
    endtask

    task automatic report_counts();
        $display("Checked %0d reads and %0d writes: %0d mismatches, %0d other errors",
                 reads, writes, mismatches, failures);
    endtask

    initial begin
        periph_pkg::addr_t a;
        logic              is_sel;
        logic [31:0]       d;
        logic [31:0]       ctl;
        rst_n         <= 1'b0;
        addr          <= '0;
        data_in       <= '0;
        write_n       <= periph_pkg::XFER_NONE;
        read_n        <= periph_pkg::XFER_NONE;
        read_complete <= 1'b0;
        ui_in         <= '0;
        lfsr_state = 32'ha8af_e2f9;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        // Select registers straight out of reset
        for (int k = 0; k < `PERI_PINS; k++) begin
            transfer({1'b0, 4'(`GPIO_SLOT), 6'(`GPIO_SEL_BASE + 4 * k)}, '0,
                     periph_pkg::XFER_32, 1'b0, '0);
        end
        for (int n = 0; n < N_RANDOM; n++) begin
            pick_address(a, is_sel);
            d   = draw_bits(32);
            ctl = draw_bits(13);
            // Selects lean toward the GPIO register and the two peripherals
            if (is_sel && ctl[12:11] == 2'b00) begin
                d[4:0] = 5'(`GPIO_SLOT);
            end else if (is_sel && ctl[12:11] == 2'b01) begin
                d[4:0] = 5'(`WREG_SLOT);
            end else if (is_sel && ctl[12:11] == 2'b10) begin
                d[4:0] = {1'b1, 4'(`BREG_SLOT)};
            end
            transfer(a, d, (ctl[1:0] == 2'b11) ? periph_pkg::XFER_32
                                               : periph_pkg::xfer_e'(ctl[1:0]),
                     ctl[2], ctl[10:3]);
        end
        repeat (3) @(posedge clk);
        report_counts();
        if (mismatches == 0 && failures == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: transfers still running after %0d cycles", CYCLE_LIMIT);
            report_counts();
            $display("Done: errors found");
            $finish;
        end
    end

endmodule
